// ==== Makefile ====
# Verilator build and run for the SPI slave testbench

VERILATOR ?= verilator
TOP       ?= spi_slave_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== design/spi_frame_engine.sv ====
// SPI frame engine for 16-bit command plus data frames
// Counts sample edges, decodes the command byte and shifts read data to miso
`timescale 1ns/100ps
`default_nettype none

module spi_frame_engine
    import spi_slave_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample_stb,
    input  logic                  shift_stb,
    input  logic                  frame_start,
    input  logic                  frame_end,
    input  logic                  selected,
    input  logic                  mosi_sync,
    input  logic [SPI_DATA_W-1:0] rd_data,
    output logic [SPI_ADDR_W-1:0] rd_addr,
    output logic                  wr_en,
    output logic [SPI_ADDR_W-1:0] wr_addr,
    output logic [SPI_DATA_W-1:0] wr_data,
    output logic                  miso,
    output logic                  miso_oe
);

    // Sample count, saturates at a full frame
    logic [4:0]            bit_cnt;
    logic                  cnt_full;
    // Receive shifter, MSB first
    logic [SPI_DATA_W-1:0] rx_shift;
    logic [SPI_DATA_W-1:0] rx_next;

    // Latched command byte
    logic                  cmd_write;
    logic [SPI_ADDR_W-1:0] cmd_addr;

    // Sample strobes that close the command and data bytes
    logic                  cmd_done;
    logic                  data_done;

    // Transmit side
    logic [2:0]            tx_idx;
    logic                  tx_busy;

    assign cnt_full  = (bit_cnt == 5'(SPI_FRAME_BITS));
    assign rx_next   = {rx_shift[SPI_DATA_W-2:0], mosi_sync};
    assign cmd_done  = sample_stb && (bit_cnt == 5'(SPI_DATA_W - 1));
    assign data_done = sample_stb && (bit_cnt == 5'(SPI_FRAME_BITS - 1));

    // ------------------------------------------------------------------
    // Receive path
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (frame_start || frame_end) begin
            bit_cnt <= '0;
        end else if (sample_stb && !cnt_full) begin
            bit_cnt <= bit_cnt + 5'd1;
        end
    end

    // Bits beyond the 16th leave the shifter alone
    always_ff @(posedge clk) begin
        if (sample_stb && !cnt_full) begin
            rx_shift <= rx_next;
        end
    end

    // Command byte is complete on the 8th sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_write <= 1'b0;
            cmd_addr  <= '0;
        end else if (frame_start || frame_end) begin
            cmd_write <= 1'b0;
        end else if (cmd_done) begin
            cmd_write <= rx_next[SPI_CMD_WRITE_BIT];
            // Bits 6:3 are dropped here
            cmd_addr  <= rx_next[SPI_ADDR_W-1:0];
        end
    end

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    // One-cycle pulse right after the 16th sample strobe
    // A short frame never reaches data_done, so it writes nothing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= data_done && cmd_write;
        end
    end

    // Shifter holds the full data byte while wr_en is high
    assign wr_addr = cmd_addr;
    assign wr_data = rx_shift;
    assign rd_addr = cmd_addr;

    // ------------------------------------------------------------------
    // Transmit path
    // ------------------------------------------------------------------
    // miso holds 0 through the command byte
    // Eight shift strobes after the command carry bits 7 down to 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            miso    <= 1'b0;
            tx_idx  <= '0;
            tx_busy <= 1'b0;
        end else if (frame_start || frame_end) begin
            miso    <= 1'b0;
            tx_busy <= 1'b0;
        end else if (cmd_done) begin
            tx_idx  <= 3'(SPI_DATA_W - 1);
            tx_busy <= 1'b1;
        end else if (shift_stb && tx_busy) begin
            miso   <= rd_data[tx_idx];
            tx_idx <= tx_idx - 3'd1;
            // Last data bit placed, later shift edges are ignored
            if (tx_idx == 3'd0) begin
                tx_busy <= 1'b0;
            end
        end
    end

    // Drive the line only while chip select is seen low
    assign miso_oe = selected;

endmodule

`default_nettype wire

// ==== design/spi_pin_sync.sv ====
// SPI pin synchronizer and edge detector
// Turns sck and cs_n into one-cycle sample, shift and frame strobes in clk
`timescale 1ns/100ps
`default_nettype none

module spi_pin_sync
    import spi_slave_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic sck,
    input  logic cs_n,
    input  logic mosi,
    input  logic cpha,
    output logic mosi_sync,
    output logic sample_stb,
    output logic shift_stb,
    output logic frame_start,
    output logic frame_end,
    output logic selected
);

    // Synchronizer chains, oldest sample in the top bit
    logic [SPI_SYNC_STAGES-1:0] sck_sync;
    logic [SPI_SYNC_STAGES-1:0] cs_sync;
    logic [SPI_SYNC_STAGES-1:0] mosi_pipe;

    // Edge register stage
    logic sck_d;
    logic cs_d;
    logic mosi_d;

    logic sck_s;
    logic cs_s;
    logic sck_rise;
    logic sck_fall;

    assign sck_s = sck_sync[SPI_SYNC_STAGES-1];
    assign cs_s  = cs_sync[SPI_SYNC_STAGES-1];

    // Clock polarity is fixed at idle low
    assign sck_rise = sck_s & ~sck_d;
    assign sck_fall = ~sck_s & sck_d;

    // ------------------------------------------------------------------
    // Two flops per pin, then one edge register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sck_sync    <= '0;
            cs_sync     <= '1;
            mosi_pipe   <= '0;
            sck_d       <= 1'b0;
            cs_d        <= 1'b1;
            mosi_d      <= 1'b0;
            sample_stb  <= 1'b0;
            shift_stb   <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[SPI_SYNC_STAGES-2:0], sck};
            cs_sync   <= {cs_sync[SPI_SYNC_STAGES-2:0], cs_n};
            mosi_pipe <= {mosi_pipe[SPI_SYNC_STAGES-2:0], mosi};
            sck_d     <= sck_s;
            cs_d      <= cs_s;
            // Delayed with the strobes so data lines up with sample_stb
            mosi_d    <= mosi_pipe[SPI_SYNC_STAGES-1];
            // cpha 0 samples on rising sck, cpha 1 on falling sck
            // No sck edge counts while the slave is deselected
            sample_stb  <= (cpha ? sck_fall : sck_rise) & ~cs_s;
            shift_stb   <= (cpha ? sck_rise : sck_fall) & ~cs_s;
            frame_start <= cs_d & ~cs_s;
            frame_end   <= ~cs_d & cs_s;
        end
    end

    assign mosi_sync = mosi_d;
    // Level, valid in step with frame_start and frame_end
    assign selected  = ~cs_d;

endmodule

`default_nettype wire

// ==== design/spi_reg_file.sv ====
// SPI slave register bank
// Identity byte at address 0, gpio register at 1, scratch registers above
`timescale 1ns/100ps
`default_nettype none

module spi_reg_file
    import spi_slave_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  logic [SPI_ADDR_W-1:0] wr_addr,
    input  logic [SPI_DATA_W-1:0] wr_data,
    input  logic [SPI_ADDR_W-1:0] rd_addr,
    output logic [SPI_DATA_W-1:0] rd_data,
    output logic [SPI_DATA_W-1:0] gpio_out
);

    // Writable registers only, address 0 has no storage
    logic [SPI_DATA_W-1:0] regs [1:SPI_NUM_REGS-1];

    logic wr_ok;

    // Address 0 is read-only, writes there vanish
    assign wr_ok = wr_en && (wr_addr != '0);

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < SPI_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------
    // Combinational, the frame engine samples it at its shift strobes
    always_comb begin
        if (rd_addr == '0) begin
            rd_data = SPI_ID_VALUE;
        end else begin
            rd_data = regs[rd_addr];
        end
    end

    // gpio pins follow register 1 directly
    assign gpio_out = regs[SPI_GPIO_ADDR];

endmodule

`default_nettype wire

// ==== design/spi_slave_pkg.sv ====
// Shared constants for the register-access SPI slave
// Widths, register map and command byte layout
`default_nettype none

package spi_slave_pkg;

    // ------------------------------------------------------------------
    // Word and frame sizes
    // ------------------------------------------------------------------
    // One register and one byte on the wire
    localparam int SPI_DATA_W = 8;
    localparam int SPI_ADDR_W = 3;
    localparam int SPI_NUM_REGS = 8;
    // Command byte plus data byte
    localparam int SPI_FRAME_BITS = 16;

    // ------------------------------------------------------------------
    // Command byte and register map
    // ------------------------------------------------------------------
    // Set means write, clear means read; bits 6:3 are don't care
    localparam int SPI_CMD_WRITE_BIT = 7;
    // Register 0 reads back this identity byte
    localparam logic [SPI_DATA_W-1:0] SPI_ID_VALUE = 8'hA5;
    // Register that drives the gpio pins
    localparam logic [SPI_ADDR_W-1:0] SPI_GPIO_ADDR = 3'd1;

    // Flops per pin in the input synchronizers
    localparam int SPI_SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== design/spi_slave_top.sv ====
// Register-access SPI slave, top level
// Pin synchronizer, frame engine and register bank in the clk domain
`timescale 1ns/100ps
`default_nettype none

module spi_slave_top
    import spi_slave_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sck,
    input  logic                  cs_n,
    input  logic                  mosi,
    input  logic                  cpha,
    output logic                  miso,
    output logic                  miso_oe,
    output logic [SPI_DATA_W-1:0] gpio_out
);

    // Synchronizer to frame engine
    logic mosi_sync;
    logic sample_stb;
    logic shift_stb;
    logic frame_start;
    logic frame_end;
    logic selected;

    // Frame engine to register bank
    logic [SPI_ADDR_W-1:0] rd_addr;
    logic [SPI_DATA_W-1:0] rd_data;
    logic                  wr_en;
    logic [SPI_ADDR_W-1:0] wr_addr;
    logic [SPI_DATA_W-1:0] wr_data;

    // ------------------------------------------------------------------
    // Pin front end
    // ------------------------------------------------------------------
    spi_pin_sync i_spi_pin_sync (
        .clk         (clk),
        .rst         (rst),
        .sck         (sck),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .cpha        (cpha),
        .mosi_sync   (mosi_sync),
        .sample_stb  (sample_stb),
        .shift_stb   (shift_stb),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .selected    (selected)
    );

    // ------------------------------------------------------------------
    // Frame decode and register bank
    // ------------------------------------------------------------------
    spi_frame_engine i_spi_frame_engine (
        .clk         (clk),
        .rst         (rst),
        .sample_stb  (sample_stb),
        .shift_stb   (shift_stb),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .selected    (selected),
        .mosi_sync   (mosi_sync),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .miso        (miso),
        .miso_oe     (miso_oe)
    );

    spi_reg_file i_spi_reg_file (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .gpio_out (gpio_out)
    );

endmodule

`default_nettype wire

// ==== list.f ====
design/spi_slave_pkg.sv
design/spi_pin_sync.sv
design/spi_frame_engine.sv
design/spi_reg_file.sv
design/spi_slave_top.sv
verification/spi_slave_props.sv
verification/spi_slave_checker.sv
verification/spi_slave_tb.sv

// ==== verification/spi_slave_checker.sv ====
// SPI slave checker
// Decodes frames from the pins, models the registers, compares miso and gpio_out
`timescale 1ns/100ps
`default_nettype none

module spi_slave_checker
    import spi_slave_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sck,
    input  logic                  cs_n,
    input  logic                  mosi,
    input  logic                  cpha,
    input  logic                  miso,
    input  logic                  miso_oe,
    input  logic [SPI_DATA_W-1:0] gpio_out,
    input  logic [SPI_DATA_W-1:0] exp_data,
    output int                    mismatch_count
);

    // Register model, entry 0 fixed at the identity byte
    logic [SPI_DATA_W-1:0] model [0:SPI_NUM_REGS-1];

    logic        sck_q;
    // cs_n history, oldest in bit 2, matches the DUT select latency
    logic [2:0]  cs_hist;
    int          bit_cnt;
    logic [15:0] rx;
    logic [15:0] rx_next;
    logic [7:0]  rd_cap;
    logic [7:0]  rd_word;
    logic [2:0]  addr;
    int          gpio_wait;
    logic        sample_edge;
    // Errors found in the current cycle
    int          errs;

    assign sample_edge = !cs_n && (cpha ? (sck_q && !sck) : (!sck_q && sck));
    assign rx_next = {rx[14:0], mosi};
    assign rd_word = {rd_cap[6:0], miso};
    // Only bits 2:0 of the command select a register
    assign addr    = rx_next[10:8];

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model[0] <= SPI_ID_VALUE;
            for (int i = 1; i < SPI_NUM_REGS; i++) begin
                model[i] <= '0;
            end
            sck_q <= 1'b0;
            cs_hist <= 3'b111;
            bit_cnt <= 0;
            rx <= '0;
            rd_cap <= '0;
            gpio_wait <= 0;
            mismatch_count <= 0;
        end else begin
            errs = 0;
            sck_q <= sck;
            cs_hist <= {cs_hist[1:0], cs_n};

            // Output enable tracks select 3 cycles late
            if (miso_oe !== ~cs_hist[2]) begin
                errs = errs + 1;
                $display("Mismatch at %0t: signal miso_oe expected %b got %b",
                         $time, ~cs_hist[2], miso_oe);
            end

            // gpio_out is checked every cycle outside the update window
            if (gpio_wait > 0) begin
                gpio_wait <= gpio_wait - 1;
            end else if (gpio_out !== model[SPI_GPIO_ADDR]) begin
                errs = errs + 1;
                $display("Mismatch at %0t: signal gpio_out expected %h got %h",
                         $time, model[SPI_GPIO_ADDR], gpio_out);
            end

            // ----------------------------------------------------------
            // Frame decode
            // ----------------------------------------------------------
            if (cs_n) begin
                bit_cnt <= 0;
            end else if (sample_edge && bit_cnt < SPI_FRAME_BITS) begin
                rx <= rx_next;
                bit_cnt <= bit_cnt + 1;
                if (bit_cnt >= SPI_DATA_W) begin
                    rd_cap <= rd_word;
                end
                if (bit_cnt == SPI_FRAME_BITS - 1) begin
                    if (rx_next[15]) begin
                        if (addr != 3'd0) begin
                            model[addr] <= rx_next[7:0];
                        end
                        // New value due at most 5 cycles after the sck edge
                        if (addr == SPI_GPIO_ADDR) begin
                            gpio_wait <= 4;
                        end
                    end else begin
                        if (rd_word !== model[addr]) begin
                            errs = errs + 1;
                            $display("Mismatch at %0t: signal miso expected %h got %h",
                                     $time, model[addr], rd_word);
                        end
                        if (rd_word !== exp_data) begin
                            errs = errs + 1;
                            $display("Mismatch at %0t: signal miso expected %h (tests file) got %h",
                                     $time, exp_data, rd_word);
                        end
                    end
                end
            end
            mismatch_count <= mismatch_count + errs;
        end
    end

endmodule

`default_nettype wire

// ==== verification/spi_slave_props.sv ====
// Frame engine assertions
// Write pulse shape, quiet miso in the command byte, output enable
`timescale 1ns/100ps
`default_nettype none

module spi_slave_props
    import spi_slave_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       wr_en,
    input logic       miso,
    input logic       miso_oe,
    input logic       selected,
    input logic       frame_start,
    input logic       frame_end,
    input logic [4:0] bit_cnt
);

    // Write strobe lasts one cycle
    a_wr_single: assert property (@(posedge clk) disable iff (rst) wr_en |=> !wr_en)
        else $error("wr_en stayed high for two cycles");

    // Nothing is driven before the command byte is complete
    a_miso_cmd: assert property (@(posedge clk) disable iff (rst)
        (bit_cnt < 5'(SPI_DATA_W)) |-> !miso)
        else $error("miso high during the command byte");

    // Output enable moves only together with a frame strobe
    a_oe_frame: assert property (@(posedge clk) disable iff (rst)
        (miso_oe != $past(miso_oe)) |-> (frame_start || frame_end))
        else $error("miso_oe changed without a frame strobe");

    a_wr_sel: assert property (@(posedge clk) disable iff (rst) $rose(wr_en) |-> selected)
        else $error("wr_en rose while deselected");

endmodule

bind spi_frame_engine spi_slave_props i_spi_slave_props (
    .clk         (clk),
    .rst         (rst),
    .wr_en       (wr_en),
    .miso        (miso),
    .miso_oe     (miso_oe),
    .selected    (selected),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .bit_cnt     (bit_cnt)
);

`default_nettype wire

// ==== verification/spi_slave_tb.sv ====
// Testbench for the register-access SPI slave
// Reads transfers from the tests file and bit-bangs them as an SPI master
`timescale 1ns/100ps
`default_nettype none

module spi_slave_tb
    import spi_slave_pkg::*;
();

    // sck half period in clk cycles
    localparam int HALF = 5;
    // Longest wait for miso_oe to follow cs_n
    localparam int OE_TIMEOUT = 20;

    logic clk;
    logic rst;
    logic sck;
    logic cs_n;
    logic mosi;
    logic cpha;
    wire  miso;
    wire  miso_oe;
    wire  [SPI_DATA_W-1:0] gpio_out;

    // Expected read data for the current transfer, from the tests file
    logic [SPI_DATA_W-1:0] exp_data;
    int mismatch_count;
    int fail_count;

    spi_slave_top i_spi_slave_top (
        .clk      (clk),
        .rst      (rst),
        .sck      (sck),
        .cs_n     (cs_n),
        .mosi     (mosi),
        .cpha     (cpha),
        .miso     (miso),
        .miso_oe  (miso_oe),
        .gpio_out (gpio_out)
    );

    spi_slave_checker i_spi_slave_checker (
        .clk            (clk),
        .rst            (rst),
        .sck            (sck),
        .cs_n           (cs_n),
        .mosi           (mosi),
        .cpha           (cpha),
        .miso           (miso),
        .miso_oe        (miso_oe),
        .gpio_out       (gpio_out),
        .exp_data       (exp_data),
        .mismatch_count (mismatch_count)
    );

    // ------------------------------------------------------------------
    // Clock and watchdog
    // ------------------------------------------------------------------
    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    initial begin
        #1000000;
        $display("Timeout: the simulation did not reach its end in time");
        $display("*** FAILED ***");
        $finish;
    end

    // Inputs change 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Wait for miso_oe to reach a level, bounded
    task automatic wait_oe(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (miso_oe !== level && cnt < OE_TIMEOUT) begin
            step(1);
            cnt++;
        end
        if (miso_oe !== level) begin
            fail_count++;
            $display("Timeout at %0t: miso_oe did not go %0d after %s", $time, level, what);
        end
    endtask

    // ------------------------------------------------------------------
    // One SPI frame, nbits long, MSB first
    // ------------------------------------------------------------------
    task automatic send_frame(input logic mode, input logic [7:0] cmd,
                              input logic [7:0] data, input int nbits);
        logic [15:0] word;
        word = {cmd, data};
        // Mode only changes while deselected
        cpha = mode;
        step(2);
        cs_n = 1'b0;
        wait_oe(1'b1, "cs_n fell");
        step(HALF);
        for (int i = 0; i < nbits; i++) begin
            if (!mode) begin
                // Data set up before the rising sample edge
                mosi = word[15-i];
                step(HALF);
                sck = 1'b1;
                step(HALF);
                sck = 1'b0;
            end else begin
                // Data changes on rising, sampled on falling
                sck  = 1'b1;
                mosi = word[15-i];
                step(HALF);
                sck = 1'b0;
                step(HALF);
            end
        end
        step(HALF);
        cs_n = 1'b1;
        mosi = 1'b0;
        wait_oe(1'b0, "cs_n rose");
        step(8);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int fd;
        int n;
        int mode;
        int tests_run;
        string line;
        logic [7:0] op;
        logic [7:0] cmd_lo;
        logic [7:0] data;

        rst = 1'b1;
        sck = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        cpha = 1'b0;
        exp_data = '0;
        fail_count = 0;
        tests_run = 0;
        step(4);
        rst = 1'b0;
        step(4);

        fd = $fopen("verification/spi_slave_tests.txt", "r");
        if (fd == 0) begin
            fail_count++;
            $display("Could not open the tests file");
        end
        while (fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %c %h %h", mode, op, cmd_lo, data);
                if (n == 4) begin
                    exp_data = data;
                    tests_run++;
                    case (op)
                        "W": send_frame(mode[0], {1'b1, cmd_lo[6:0]}, data, 16);
                        "R": send_frame(mode[0], {1'b0, cmd_lo[6:0]}, data, 16);
                        // Write that stops after 12 bits
                        "A": send_frame(mode[0], {1'b1, cmd_lo[6:0]}, data, 12);
                        default: begin
                            fail_count++;
                            $display("Unknown operation in tests file line: %s", line);
                        end
                    endcase
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (tests_run == 0) begin
            fail_count++;
            $display("No transfers were read from the tests file");
        end

        step(10);
        $display("Transfers %0d, mismatches %0d, other failures %0d",
                 tests_run, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/spi_slave_tests.txt ====
# cpha op cmd[6:0] data, hex; op W write, R read (data is the expected value)
# op A is a write aborted after 12 bits
0 R 00 A5
0 W 02 3C
0 R 02 3C
1 W 03 C9
1 R 03 C9
0 R 03 C9
1 R 02 3C
0 W 00 11
1 R 00 A5
0 W 01 5A
1 W 04 81
0 R 01 5A
1 A 04 FF
0 R 04 81
1 W 7D E7
0 R 05 E7
1 R 01 5A
